// File: src/scan_test_params.svh
// --------------------
// Sizes and field positions shared by the scan test controller
// Include where widths of the chain, the pattern or the command data are needed
// --------------------
`ifndef SCAN_TEST_PARAMS_SVH
`define SCAN_TEST_PARAMS_SVH

`define SCAN_BITS   96                          // Scan chain length in bits
`define PAT_WORD_W  16                          // Pattern memory word
`define PAT_DEPTH   (`SCAN_BITS / `PAT_WORD_W)  // Words in pattern memory
`define RD_WORD_W   32                          // Readout word toward software
`define CAP_WORDS   (`SCAN_BITS / `RD_WORD_W)   // Capture words readable
`define CMD_DATA_W  24                          // Command data field
`define ADDR_LSB    16                          // Address sits in data bits 23..16
`define PERIOD_W    6                           // Period, test delay and sample fields
`define DELAY_W     5                           // Clock delay field

`endif

// File: src/cmd_pkg.sv
// --------------------
// Software side of the controller
// Opcodes, the command word and status bit positions used by the command port
// --------------------
`include "scan_test_params.svh"

package cmd_pkg;

  // Command opcodes, value also selects the seen flag in status
  typedef enum logic [2:0] {
    OP_NOP          = 3'd0,
    OP_W_STATIC     = 3'd1,
    OP_R_STATIC     = 3'd2,
    OP_W_PATTERN    = 3'd3,
    OP_R_PATTERN    = 3'd4,
    OP_R_CAPTURE    = 3'd5,
    OP_STATUS_CLEAR = 3'd6,
    OP_EXECUTE      = 3'd7
  } op_t;

  // Command as presented on the port, 27 bits
  typedef struct packed {
    op_t                   op;
    logic [`CMD_DATA_W-1:0] data;  // Address in top byte for array access
  } cmd_t;

  // Status word layout
  localparam int ST_DONE      = 0;  // Last test finished
  localparam int ST_ERROR     = 1;  // Last execute rejected
  localparam int ST_SEEN_BASE = 8;  // Seen flags at base plus opcode

endpackage

// File: src/scan_pkg.sv
// --------------------
// ASIC side of the controller
// Configuration words, sequencer states and the pixel chip pin bundle
// --------------------
`include "scan_test_params.svh"

package scan_pkg;

  // Static configuration word, kept until rewritten
  typedef struct packed {
    logic [10:0]           spare;            // Bits 23..13
    logic                  super_pixel_sel;  // Bit 12
    logic                  bx_delay_sign;    // Bit 11, set moves bxclk earlier
    logic [`DELAY_W-1:0]   bx_delay;         // Bits 10..6
    logic [`PERIOD_W-1:0]  bx_period;        // Bits 5..0, in fast clock cycles
  } static_cfg_t;

  // Execute configuration, taken with the execute command
  typedef struct packed {
    logic [6:0]            spare_hi;     // Bits 23..17
    logic                  loopback;     // Bit 16, capture scan_in itself
    logic [3:0]            spare_lo;     // Bits 15..12
    logic [`PERIOD_W-1:0]  test_sample;  // Bits 11..6, capture phase
    logic [`PERIOD_W-1:0]  test_delay;   // Bits 5..0, launch phase
  } exec_cfg_t;

  // Scan sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE      = 3'd0,
    SEQ_DELAY     = 3'd1,
    SEQ_RESET_NOT = 3'd2,
    SEQ_LOAD      = 3'd3,
    SEQ_SHIFT     = 3'd4,
    SEQ_DONE      = 3'd5
  } seq_state_t;

  // Chain mode seen by the chip on scan_load
  typedef enum logic {
    SHIFT_REG = 1'b0,  // Serial shift
    LOAD_COMP = 1'b1   // Parallel load from comparators, default
  } scan_mode_t;

  // Pins toward the pixel chip
  typedef struct packed {
    logic        super_pixel_sel;
    logic        reset_not;
    logic        scan_in;
    scan_mode_t  scan_load;
    logic        bxclk_ana;
    logic        bxclk;
  } dut_pins_t;

endpackage

// File: src/cmd_regs.sv
// --------------------
// Command port of the controller
// Runs the req/ack handshake, holds static word, pattern memory and status,
// starts a scan test and muxes the readout word
// --------------------
`timescale 1ns/100ps
`include "scan_test_params.svh"

module cmd_regs import cmd_pkg::*, scan_pkg::*; (
  input  logic                  fw_pl_clk1,
  input  logic                  op_code_w_reset,
  input  cmd_t                  cmd,
  input  logic                  cmd_req,
  input  logic                  done,         // End of test from sequencer
  input  logic [`RD_WORD_W-1:0] cap_word,
  output logic                  cmd_ack,
  output logic [31:0]           read_data32,  // Valid while cmd_ack is high
  output logic [31:0]           status32,
  output static_cfg_t           static_cfg,
  output exec_cfg_t             exec_cfg,
  output logic                  start,        // One cycle test start
  output logic [`SCAN_BITS-1:0] pattern,
  output logic [7:0]            cap_addr
);

  localparam int PSEL_W = $clog2(`PAT_DEPTH);

  typedef enum logic [2:0] {HS_IDLE, HS_DECODE, HS_RESP, HS_RUN, HS_ACK, HS_REL} hs_state_t;

  hs_state_t                                hs_state;
  cmd_t                                     cmd_q;     // Command held for the whole handshake
  logic [7:0]                               rd_addr;
  logic [4:0]                               seen_idx;
  exec_cfg_t                                exec_new;
  logic                                     cfg_err;
  logic                                     pat_we;
  logic [`PAT_DEPTH-1:0][`PAT_WORD_W-1:0]   pat_mem;   // Word 0 holds chain bits 15..0

  assign rd_addr  = cmd_q.data[`ADDR_LSB +: 8];
  assign cap_addr = rd_addr;
  assign seen_idx = 5'(ST_SEEN_BASE) + 5'(cmd_q.op);
  assign exec_new = exec_cfg_t'(cmd_q.data);
  assign pattern  = pat_mem;

  // Sample point must leave room for reset and sit inside the period
  assign cfg_err = (exec_new.test_delay < 3) || (exec_new.test_delay > static_cfg.bx_period) ||
                   (exec_new.test_sample == '0) || (exec_new.test_sample > static_cfg.bx_period);

  // --------------------
  // Handshake FSM
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      hs_state   <= HS_IDLE;
      cmd_q      <= '0;
      cmd_ack    <= 1'b0;
      start      <= 1'b0;
      status32   <= '0;
      static_cfg <= '0;
      exec_cfg   <= '0;
    end else begin
      start <= 1'b0;
      case (hs_state)
        HS_IDLE: if (cmd_req) begin
          cmd_q    <= cmd;  // Software holds cmd stable from here
          hs_state <= HS_DECODE;
        end
        HS_DECODE: begin
          hs_state           <= HS_RESP;
          status32[seen_idx] <= 1'b1;
          case (cmd_q.op)
            OP_W_STATIC:     static_cfg <= static_cfg_t'(cmd_q.data);
            OP_STATUS_CLEAR: status32 <= '0;  // Overrides own seen flag
            OP_EXECUTE: begin
              exec_cfg           <= exec_new;
              status32[ST_DONE]  <= 1'b0;
              status32[ST_ERROR] <= cfg_err;
              if (!cfg_err) begin
                start    <= 1'b1;
                hs_state <= HS_RUN;  // Ack waits for the sequencer
              end
            end
            default: ;
          endcase
        end
        HS_RESP: begin
          cmd_ack  <= 1'b1;
          hs_state <= HS_ACK;
        end
        HS_RUN: if (done) begin
          status32[ST_DONE] <= 1'b1;
          cmd_ack           <= 1'b1;
          hs_state          <= HS_ACK;
        end
        HS_ACK:  if (!cmd_req) hs_state <= HS_REL;
        HS_REL: begin
          cmd_ack  <= 1'b0;
          hs_state <= HS_IDLE;
        end
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  // Pattern memory write drops out of range addresses
  assign pat_we = (hs_state == HS_DECODE) && (cmd_q.op == OP_W_PATTERN) &&
                  (rd_addr < `PAT_DEPTH);

  always_ff @(posedge fw_pl_clk1) begin
    if (pat_we) pat_mem[rd_addr[PSEL_W-1:0]] <= cmd_q.data[`PAT_WORD_W-1:0];
  end

  function automatic logic [`PAT_WORD_W-1:0] pat_word(input logic [7:0] a);
    logic [`PAT_WORD_W-1:0] w;
    w = '0;
    if (a < `PAT_DEPTH) w = pat_mem[a[PSEL_W-1:0]];
    return w;
  endfunction

  // --------------------
  // Readout mux
  always_comb begin
    case (cmd_q.op)
      OP_R_STATIC:  read_data32 = {8'h00, static_cfg};
      OP_R_PATTERN: read_data32 = {pat_word(rd_addr + 8'd1), pat_word(rd_addr)};  // Pair of words
      OP_R_CAPTURE: read_data32 = cap_word;
      default:      read_data32 = '0;
    endcase
  end

  // Ack only ever answers a request pending at the edge that raises it
  ack_needs_req: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    $rose(cmd_ack) |-> $past(cmd_req));

endmodule

// File: src/bx_clock_gen.sv
// --------------------
// Bunch-crossing clock generator
// Phase counter plus bxclk_ana and a bxclk shifted later or earlier by bx_delay
// --------------------
`timescale 1ns/100ps
`include "scan_test_params.svh"

module bx_clock_gen import scan_pkg::*; (
  input  logic                 fw_pl_clk1,
  input  logic                 op_code_w_reset,
  input  static_cfg_t          static_cfg,
  output logic [`PERIOD_W-1:0] phase_cnt,  // 1 to period, 0 when stopped
  output logic                 bxclk_ana,
  output logic                 bxclk
);

  localparam int PW = `PERIOD_W;

  logic [PW-1:0] period;
  logic [PW-1:0] half;
  logic [PW-1:0] dly;
  logic [PW-1:0] shifted;  // Phase as seen by the shifted window
  logic [PW:0]   sum;

  assign period = static_cfg.bx_period;
  assign half   = period >> 1;
  assign dly    = (PW'(static_cfg.bx_delay) > period) ? period : PW'(static_cfg.bx_delay);

  // Phase counter, stopped for periods below 2
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset || period < 2) begin
      phase_cnt <= '0;
    end else if (phase_cnt >= period) begin
      phase_cnt <= PW'(1);  // Wrap, also catches a shrunk period
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // Shift the phase modulo the period
  always_comb begin
    if (static_cfg.bx_delay_sign) begin
      sum = {1'b0, phase_cnt} + {1'b0, dly};                   // Earlier
    end else begin
      sum = {1'b0, phase_cnt} + {1'b0, period} - {1'b0, dly};  // Later
    end
    if (sum > {1'b0, period}) shifted = PW'(sum - {1'b0, period});
    else                      shifted = sum[PW-1:0];
  end

  // High for counts 1 to half period
  assign bxclk_ana = (phase_cnt != '0) && (phase_cnt <= half);
  assign bxclk     = (phase_cnt != '0) && (shifted != '0) && (shifted <= half);

  // --------------------
  phase_in_period: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    $stable(static_cfg.bx_period) |-> phase_cnt <= static_cfg.bx_period);

endmodule

// File: src/scan_sequencer.sv
// --------------------
// Scan test sequencer
// Waits a period, pulses reset_not low, then shifts the pattern out on scan_in
// one bit per bunch crossing at the test_delay phase
// --------------------
`timescale 1ns/100ps
`include "scan_test_params.svh"

module scan_sequencer import scan_pkg::*; (
  input  logic                  fw_pl_clk1,
  input  logic                  op_code_w_reset,
  input  logic                  start,
  input  static_cfg_t           static_cfg,
  input  exec_cfg_t             exec_cfg,
  input  logic [`SCAN_BITS-1:0] pattern,
  input  logic [`PERIOD_W-1:0]  phase_cnt,
  output seq_state_t            state,
  output logic                  reset_not,
  output logic                  scan_in,
  output scan_mode_t            scan_load,
  output logic                  super_pixel_sel,
  output logic                  done         // One cycle in SEQ_DONE
);

  localparam int CNT_W = $clog2(`SCAN_BITS + 1);

  logic [`SCAN_BITS-1:0] sreg;     // Outgoing bits, LSB next
  logic [CNT_W-1:0]      bit_cnt;  // Bits put on scan_in
  logic [`PERIOD_W-1:0]  cyc_cnt;  // Cycles spent in a timed state
  logic                  period_end;
  logic                  send_tick;
  logic                  sample_tick;
  logic                  all_sent;

  assign period_end  = (cyc_cnt == static_cfg.bx_period - 1'b1);
  assign send_tick   = (phase_cnt == exec_cfg.test_delay);
  assign sample_tick = (phase_cnt == exec_cfg.test_sample);
  assign all_sent    = (bit_cnt == CNT_W'(`SCAN_BITS));

  // --------------------
  // Test FSM
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      state   <= SEQ_IDLE;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      scan_in <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: if (start) begin
          state   <= SEQ_DELAY;
          cyc_cnt <= '0;
        end
        SEQ_DELAY: begin
          if (period_end) begin
            state   <= SEQ_RESET_NOT;
            cyc_cnt <= '0;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        SEQ_RESET_NOT: begin
          if (period_end) state <= SEQ_LOAD;
          else            cyc_cnt <= cyc_cnt + 1'b1;
        end
        SEQ_LOAD: begin
          state   <= SEQ_SHIFT;
          bit_cnt <= '0;
          scan_in <= 1'b0;
        end
        SEQ_SHIFT: begin
          if (send_tick && !all_sent) begin
            scan_in <= sreg[0];
            bit_cnt <= bit_cnt + 1'b1;
          end
          // Leave on the sample that catches the last bit
          if (sample_tick && all_sent) begin
            state   <= SEQ_DONE;
            scan_in <= 1'b0;
          end
        end
        SEQ_DONE: state <= SEQ_IDLE;
        default:  state <= SEQ_IDLE;
      endcase
    end
  end

  // Pattern image shift register
  always_ff @(posedge fw_pl_clk1) begin
    if (state == SEQ_LOAD) begin
      sreg <= pattern;
    end else if (state == SEQ_SHIFT && send_tick && !all_sent) begin
      sreg <= sreg >> 1;
    end
  end

  // Pin decode, idle values outside a test
  assign reset_not       = (state != SEQ_IDLE) && (state != SEQ_RESET_NOT);
  assign scan_load       = (state == SEQ_SHIFT) ? SHIFT_REG : LOAD_COMP;
  assign super_pixel_sel = (state != SEQ_IDLE) && static_cfg.super_pixel_sel;
  assign done            = (state == SEQ_DONE);

  start_only_idle: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    start |-> state == SEQ_IDLE);

endmodule

// File: src/scan_capture.sv
// --------------------
// Capture register for the scan chain
// Samples scan_out, or scan_in in loopback, at the test_sample phase
// --------------------
`timescale 1ns/100ps
`include "scan_test_params.svh"

module scan_capture import scan_pkg::*; (
  input  logic                  fw_pl_clk1,
  input  logic                  op_code_w_reset,
  input  seq_state_t            state,
  input  exec_cfg_t             exec_cfg,
  input  logic [`PERIOD_W-1:0]  phase_cnt,
  input  logic                  scan_in,
  input  logic                  scan_out,   // From the chip
  input  logic [7:0]            cap_addr,
  output logic [`RD_WORD_W-1:0] cap_word
);

  localparam int SEL_W = $clog2(`CAP_WORDS);

  logic [`SCAN_BITS-1:0]                  cap_reg;    // Bit i is the i-th bit sent
  logic [`CAP_WORDS-1:0][`RD_WORD_W-1:0]  cap_words;
  logic [SEL_W-1:0]                       word_sel;
  logic                                   cap_bit;

  assign cap_bit = exec_cfg.loopback ? scan_in : scan_out;

  // New bit at MSB, shift right, held between tests
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      cap_reg <= '0;
    end else if (state == SEQ_SHIFT && phase_cnt == exec_cfg.test_sample) begin
      cap_reg <= {cap_bit, cap_reg[`SCAN_BITS-1:1]};
    end
  end

  // --------------------
  // Word readout
  assign cap_words = cap_reg;
  assign word_sel  = cap_addr[SEL_W-1:0];
  assign cap_word  = (cap_addr < `CAP_WORDS) ? cap_words[word_sel] : '0;  // Past the end reads 0

endmodule

// File: src/scan_test_top.sv
// --------------------
// Scan test controller top level
// Command port on one side, pixel chip pins on the other
// --------------------
`timescale 1ns/100ps
`include "scan_test_params.svh"

module scan_test_top import cmd_pkg::*, scan_pkg::*; (
  input  logic        fw_pl_clk1,
  input  logic        op_code_w_reset,
  input  cmd_t        cmd,
  input  logic        cmd_req,
  input  logic        scan_out,
  output logic        cmd_ack,
  output logic [31:0] read_data32,
  output logic [31:0] status32,
  output dut_pins_t   dut_pins
);

  static_cfg_t           static_cfg;
  exec_cfg_t             exec_cfg;
  logic                  start;
  logic                  done;
  logic [`SCAN_BITS-1:0] pattern;
  logic [7:0]            cap_addr;
  logic [`RD_WORD_W-1:0] cap_word;
  logic [`PERIOD_W-1:0]  phase_cnt;
  logic                  bxclk_ana;
  logic                  bxclk;
  seq_state_t            state;
  logic                  reset_not;
  logic                  scan_in;
  scan_mode_t            scan_load;
  logic                  super_pixel_sel;

  cmd_regs u_cmd_regs (
    .fw_pl_clk1, .op_code_w_reset, .cmd, .cmd_req, .done, .cap_word,
    .cmd_ack, .read_data32, .status32, .static_cfg, .exec_cfg, .start, .pattern, .cap_addr
  );

  bx_clock_gen u_bx_clock_gen (
    .fw_pl_clk1, .op_code_w_reset, .static_cfg, .phase_cnt, .bxclk_ana, .bxclk
  );

  scan_sequencer u_scan_sequencer (
    .fw_pl_clk1, .op_code_w_reset, .start, .static_cfg, .exec_cfg, .pattern, .phase_cnt,
    .state, .reset_not, .scan_in, .scan_load, .super_pixel_sel, .done
  );

  scan_capture u_scan_capture (
    .fw_pl_clk1, .op_code_w_reset, .state, .exec_cfg, .phase_cnt, .scan_in, .scan_out,
    .cap_addr, .cap_word
  );

  // Chip pin bundle
  assign dut_pins = '{super_pixel_sel: super_pixel_sel, reset_not: reset_not,
                      scan_in: scan_in, scan_load: scan_load,
                      bxclk_ana: bxclk_ana, bxclk: bxclk};

endmodule

// File: verification/tb_scan_test.sv
// --------------------
// Directed testbench for the scan test controller
// Drives the four-phase command port and checks readback, clocks and scan capture
// --------------------
`timescale 1ns/100ps
`include "scan_test_params.svh"

module tb_scan_test import cmd_pkg::*, scan_pkg::*; ();

  localparam int ACK_LIMIT = 4000;  // Ack wait in cycles covers a full 96 bit test at period 10
  localparam int BX_PERIOD = 10;

  logic        fw_pl_clk1;
  logic        op_code_w_reset;
  cmd_t        cmd;
  logic        cmd_req;
  logic        scan_out;
  logic        cmd_ack;
  logic [31:0] read_data32;
  logic [31:0] status32;
  dut_pins_t   dut_pins;

  logic [31:0]            lfsr = 32'h276f_98bd;
  logic [`PAT_WORD_W-1:0] pat [`PAT_DEPTH];  // Copy of what was written
  logic [31:0]            exp_status = '0;   // Status model
  int                     errors = 0;
  int                     checks = 0;
  int                     tests = 0;
  int                     tests_failed = 0;

  // Pin monitor state
  logic rn_prev = 1'b0;
  logic rn_fall = 1'b0;
  logic rn_pulsed = 1'b0;
  logic req_prev = 1'b0;
  int   shift_cycles = 0;
  int   shift_bad = 0;

  scan_test_top dut (.*);

  initial begin
    fw_pl_clk1 = 1'b0;
    forever #20 fw_pl_clk1 = ~fw_pl_clk1;
  end

  // Chip model inverts scan_in back onto scan_out
  initial begin
    scan_out = 1'b0;
    forever begin
      @(posedge fw_pl_clk1);
      #1;
      scan_out = ~dut_pins.scan_in;
    end
  end

  always @(negedge fw_pl_clk1) begin
    if (cmd_req && !req_prev) begin  // New command restarts pulse tracking
      rn_fall   = 1'b0;
      rn_pulsed = 1'b0;
    end
    if (rn_prev && !dut_pins.reset_not) rn_fall = 1'b1;
    if (!rn_prev && dut_pins.reset_not && rn_fall) rn_pulsed = 1'b1;  // Low pulse complete
    if (dut_pins.scan_load == SHIFT_REG) begin
      shift_cycles++;
      if (!rn_pulsed || !dut_pins.reset_not) shift_bad++;
    end
    rn_prev  = dut_pins.reset_not;
    req_prev = cmd_req;
  end

  // --------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_word(output logic [`PAT_WORD_W-1:0] w);
    for (int i = 0; i < `PAT_WORD_W; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];  // One step per bit
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h (done %b error %b)", $time, name, got, exp,
               got[ST_DONE], got[ST_ERROR]);
    end
  endtask

  task automatic check_pins(input string name, input dut_pins_t got, input dut_pins_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // --------------------
  task automatic wait_ack(input logic level, output int n);
    n = 0;
    while (cmd_ack !== level && n < ACK_LIMIT) begin
      @(posedge fw_pl_clk1);
      #1;
      n++;
    end
    if (cmd_ack !== level) begin
      $display("Timeout, cmd_ack never went to %b within %0d cycles", level, ACK_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  endtask

  // Full four-phase handshake with data and status taken while ack is high
  task automatic send_cmd(input op_t op, input logic [23:0] data, input bit fixed_lat,
                          output logic [31:0] rdata, output logic [31:0] st_ack);
    int n;
    @(posedge fw_pl_clk1);
    #1;
    cmd     = '{op: op, data: data};
    cmd_req = 1'b1;
    wait_ack(1'b1, n);
    rdata  = read_data32;
    st_ack = status32;
    if (fixed_lat) check_word("cmd_ack latency", 32'(n), 32'd3);  // Two edges after req seen
    cmd_req = 1'b0;
    exp_status[ST_SEEN_BASE + int'(op)] = 1'b1;
    if (op == OP_STATUS_CLEAR) exp_status = '0;
    wait_ack(1'b0, n);
  endtask

  task automatic finish_test(input int num, input string name, input int err_start);
    tests++;
    if (errors != err_start) tests_failed++;
    $display("Test %0d %s: %s", num, name, (errors == err_start) ? "ok" : "failed");
  endtask

  task automatic write_random_pattern();
    logic [31:0] rd;
    logic [31:0] st;
    for (int a = 0; a < `PAT_DEPTH; a++) begin
      rand_word(pat[a]);
      send_cmd(OP_W_PATTERN, {8'(a), pat[a]}, 1'b1, rd, st);
    end
  endtask

  // --------------------
  task automatic test_reset_idle();
    int        e0;
    dut_pins_t idle;
    e0             = errors;
    idle           = '0;
    idle.scan_load = LOAD_COMP;
    check_word("cmd_ack", {31'b0, cmd_ack}, 32'd0);
    check_status("status32", status32, 32'd0);
    check_pins("dut_pins", dut_pins, idle);
    finish_test(1, "reset idle", e0);
  endtask

  task automatic test_storage();
    int          e0;
    logic [31:0] rd;
    logic [31:0] st;
    e0 = errors;
    send_cmd(OP_W_STATIC, 24'h5a_c3_e7, 1'b1, rd, st);
    send_cmd(OP_R_STATIC, 24'h00_0000, 1'b1, rd, st);
    check_word("read_data32 static", rd, 32'h005a_c3e7);  // Top byte zero
    check_status("status32 seen", status32, exp_status);
    write_random_pattern();
    for (int a = 0; a < `PAT_DEPTH; a += 2) begin
      send_cmd(OP_R_PATTERN, {8'(a), 16'h0}, 1'b1, rd, st);
      check_word("read_data32 pattern", rd, {pat[a+1], pat[a]});
    end
    finish_test(2, "static and pattern", e0);
  endtask

  // One period of both clocks from a rising edge of bxclk_ana
  task automatic measure_bx(input logic [4:0] dly, input logic sign);
    static_cfg_t sc;
    logic [31:0] rd;
    logic [31:0] st;
    logic        prev_ana;
    logic        prev_bx;
    int          n;
    int          ana_hi;
    int          bx_hi;
    int          rise_at;
    sc               = '0;
    sc.bx_period     = 6'(BX_PERIOD);
    sc.bx_delay      = dly;
    sc.bx_delay_sign = sign;
    send_cmd(OP_W_STATIC, sc, 1'b1, rd, st);
    n        = 0;
    prev_ana = dut_pins.bxclk_ana;
    prev_bx  = dut_pins.bxclk;
    @(posedge fw_pl_clk1);
    #1;
    while (!(!prev_ana && dut_pins.bxclk_ana) && n < 4 * BX_PERIOD) begin
      prev_ana = dut_pins.bxclk_ana;
      prev_bx  = dut_pins.bxclk;
      @(posedge fw_pl_clk1);
      #1;
      n++;
    end
    if (!(!prev_ana && dut_pins.bxclk_ana)) begin
      $display("Timeout, bxclk_ana never rose with period %0d", BX_PERIOD);
      $display("Result: FAILED");
      $finish;
    end else begin
      ana_hi  = 0;
      bx_hi   = 0;
      rise_at = -1;
      for (int k = 0; k < BX_PERIOD; k++) begin
        if (k > 0) begin
          @(posedge fw_pl_clk1);
          #1;
        end
        if (dut_pins.bxclk_ana) ana_hi++;
        if (dut_pins.bxclk) bx_hi++;
        if (!prev_bx && dut_pins.bxclk && rise_at < 0) rise_at = k;
        prev_bx = dut_pins.bxclk;
      end
      check_word("bxclk_ana high cycles", 32'(ana_hi), 32'(BX_PERIOD / 2));
      check_word("bxclk high cycles", 32'(bx_hi), 32'(BX_PERIOD / 2));
      check_word("bxclk rise offset", 32'(rise_at),
                 sign ? 32'(BX_PERIOD - int'(dly)) : 32'(dly));
    end
  endtask

  task automatic test_bx_clock();
    int e0;
    e0 = errors;
    measure_bx(5'd2, 1'b0);  // Later
    measure_bx(5'd2, 1'b1);  // Earlier
    finish_test(3, "bunch-crossing clock", e0);
  endtask

  // Sends the pattern out and compares the capture with it or its inverse
  task automatic run_scan(input int num, input string name, input logic loopback);
    int                    e0;
    int                    sc0;
    int                    sb0;
    static_cfg_t           sc;
    exec_cfg_t             ec;
    logic [31:0]           rd;
    logic [31:0]           st;
    logic [`SCAN_BITS-1:0] chain;
    e0           = errors;
    sc           = '0;
    sc.bx_period = 6'(BX_PERIOD);
    send_cmd(OP_W_STATIC, sc, 1'b1, rd, st);
    write_random_pattern();
    for (int a = 0; a < `PAT_DEPTH; a++) chain[a*`PAT_WORD_W +: `PAT_WORD_W] = pat[a];
    ec             = '0;
    ec.loopback    = loopback;
    ec.test_delay  = 6'd4;
    ec.test_sample = 6'd7;
    sc0            = shift_cycles;
    sb0            = shift_bad;
    send_cmd(OP_EXECUTE, ec, 1'b0, rd, st);
    exp_status[ST_DONE]  = 1'b1;
    exp_status[ST_ERROR] = 1'b0;
    check_status("status32 at ack", st, exp_status);
    check_word("shift phase seen", {31'b0, shift_cycles > sc0}, 32'd1);
    check_word("shift cycles without reset_not pulse", 32'(shift_bad - sb0), 32'd0);
    for (int w = 0; w <= `CAP_WORDS; w++) begin
      send_cmd(OP_R_CAPTURE, {8'(w), 16'h0}, 1'b1, rd, st);
      if (w == `CAP_WORDS) check_word("read_data32 capture end", rd, 32'd0);
      else if (loopback)   check_word("read_data32 capture", rd, chain[w*32 +: 32]);
      else                 check_word("read_data32 capture", rd, ~chain[w*32 +: 32]);
    end
    finish_test(num, name, e0);
  endtask

  task automatic test_reject_and_clear();
    int          e0;
    int          sc0;
    exec_cfg_t   ec;
    logic [31:0] rd;
    logic [31:0] st;
    e0             = errors;
    ec             = '0;
    ec.test_delay  = 6'd1;  // Below the minimum launch phase
    ec.test_sample = 6'd7;
    sc0            = shift_cycles;
    send_cmd(OP_EXECUTE, ec, 1'b1, rd, st);
    exp_status[ST_DONE]  = 1'b0;
    exp_status[ST_ERROR] = 1'b1;
    check_status("status32 at ack", st, exp_status);
    repeat (4 * BX_PERIOD) @(posedge fw_pl_clk1);  // Give a stray test time to show
    check_word("scan_load shift cycles", 32'(shift_cycles - sc0), 32'd0);
    send_cmd(OP_STATUS_CLEAR, 24'h0, 1'b1, rd, st);
    check_status("status32 cleared", status32, 32'd0);
    finish_test(6, "rejected config and clear", e0);
  endtask

  // --------------------
  initial begin
    op_code_w_reset = 1'b1;
    cmd             = '0;
    cmd_req         = 1'b0;
    repeat (10) @(posedge fw_pl_clk1);
    #1;
    op_code_w_reset = 1'b0;
    @(posedge fw_pl_clk1);
    #1;
    test_reset_idle();
    test_storage();
    test_bx_clock();
    run_scan(4, "loopback scan", 1'b1);
    run_scan(5, "inverted scan_out", 1'b0);
    test_reject_and_clear();
    $display("Tests %0d, tests failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+src
src/cmd_pkg.sv
src/scan_pkg.sv
src/cmd_regs.sv
src/bx_clock_gen.sv
src/scan_sequencer.sv
src/scan_capture.sv
src/scan_test_top.sv
verification/tb_scan_test.sv

// File: Makefile
# Verilator build for the scan test controller

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_scan_test
RTL_TOP   ?= scan_test_top
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_scan_test
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
